// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -j 0 -f sim.f \
		--top-module tb_stream_flow_control -Mdir obj_dir
	./obj_dir/Vtb_stream_flow_control | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: sim.f
src/flow_pkg.sv
src/port_fifo.sv
src/input_port_cluster.sv
src/output_port_cluster.sv
src/converge_ctrl.sv
src/counter_dump_seq.sv
src/stream_flow_control.sv
test/tb_stream_flow_control.sv

// File: src/converge_ctrl.sv
`timescale 1ns/1ps

module converge_ctrl (
    input  logic              clk,
    input  logic              reset,
    input  logic              empty       [flow_pkg::num_out_ports],
    input  flow_pkg::packet_t out_packets [flow_pkg::num_out_ports],
    output logic              rd_en_sel   [flow_pkg::num_out_ports],
    output flow_pkg::packet_t stream_out
);

    logic [$clog2(flow_pkg::num_out_ports)-1:0] last_grant;
    logic [$clog2(flow_pkg::num_out_ports)-1:0] grant_idx;
    logic                                       grant_any;
    logic                                       out_vld;
    flow_pkg::packet_t                          out_pkt;

    // round robin, search starts one past the last grant
    always_comb begin
        int cand;
        grant_any = 1'b0;
        grant_idx = last_grant;
        for (int k = 1; k <= flow_pkg::num_out_ports; k++) begin
            cand = (int'(last_grant) + k) % flow_pkg::num_out_ports;
            if (!grant_any && !empty[cand]) begin
                grant_any = 1'b1;
                grant_idx = cand[$clog2(flow_pkg::num_out_ports)-1:0];
            end
        end
    end

    // one-hot pop
    always_comb begin
        for (int i = 0; i < flow_pkg::num_out_ports; i++) begin
            rd_en_sel[i] = grant_any && (int'(grant_idx) == i);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            last_grant <= '0;
            out_vld    <= 1'b0;
        end else begin
            out_vld <= grant_any;
            if (grant_any) begin
                last_grant <= grant_idx;
            end
        end
    end

    // packet body
    always_ff @(posedge clk) begin
        if (grant_any) begin
            out_pkt <= out_packets[grant_idx];
        end
    end

    // no back-pressure, idle cycles just drop valid
    always_comb begin
        stream_out       = out_pkt;
        stream_out.valid = out_vld;
    end

endmodule

// File: src/counter_dump_seq.sv
`timescale 1ns/1ps

module counter_dump_seq (
    input  logic               clk,
    input  logic               reset,
    input  logic               is_done,
    output logic               is_done_mode,
    input  flow_pkg::cnt_t     in_full_cnt   [flow_pkg::num_in_ports],
    input  flow_pkg::cnt_t     in_empty_cnt  [flow_pkg::num_in_ports],
    input  flow_pkg::cnt_t     in_read_cnt   [flow_pkg::num_in_ports],
    input  flow_pkg::cnt_t     out_full_cnt  [flow_pkg::num_out_ports],
    input  flow_pkg::cnt_t     out_empty_cnt [flow_pkg::num_out_ports],
    output logic               dump_valid,
    output flow_pkg::payload_t dump_word,
    input  logic               dump_taken
);

    logic [$clog2(flow_pkg::dump_len+1)-1:0] widx;

    //////////////////////////////////////////////////////////////////////
    // done latch and word index
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            is_done_mode <= 1'b0;
            widx         <= '0;
        end else begin
            // sticky until reset
            if (is_done) begin
                is_done_mode <= 1'b1;
            end
            if (dump_valid && dump_taken) begin
                widx <= widx + 1'b1;
            end
        end
    end

    // index parks at dump_len, so a later is_done sends nothing
    assign dump_valid = is_done_mode && (int'(widx) != flow_pkg::dump_len);

    //////////////////////////////////////////////////////////////////////
    // word select
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        int                 w;
        int                 port_num;
        flow_pkg::cnt_tag_t tag;
        flow_pkg::cnt_t     cnt;
        w        = int'(widx);
        port_num = 0;
        tag      = flow_pkg::tag_read;
        cnt      = '0;
        // input reads, input empties, input fulls
        if (w < flow_pkg::num_in_ports) begin
            port_num = flow_pkg::in_port_base + w;
            cnt      = in_read_cnt[w];
        end else if (w < 2 * flow_pkg::num_in_ports) begin
            port_num = flow_pkg::in_port_base + w - flow_pkg::num_in_ports;
            tag      = flow_pkg::tag_empty;
            cnt      = in_empty_cnt[w - flow_pkg::num_in_ports];
        end else if (w < 3 * flow_pkg::num_in_ports) begin
            port_num = flow_pkg::in_port_base + w - 2 * flow_pkg::num_in_ports;
            tag      = flow_pkg::tag_full;
            cnt      = in_full_cnt[w - 2 * flow_pkg::num_in_ports];
        // then output fulls and output empties
        end else if (w < 3 * flow_pkg::num_in_ports + flow_pkg::num_out_ports) begin
            port_num = flow_pkg::out_port_base + w - 3 * flow_pkg::num_in_ports;
            tag      = flow_pkg::tag_full;
            cnt      = out_full_cnt[w - 3 * flow_pkg::num_in_ports];
        end else if (w < flow_pkg::dump_len) begin
            port_num = flow_pkg::out_port_base + w - 3 * flow_pkg::num_in_ports
                       - flow_pkg::num_out_ports;
            tag      = flow_pkg::tag_empty;
            cnt      = out_empty_cnt[w - 3 * flow_pkg::num_in_ports - flow_pkg::num_out_ports];
        end
        dump_word = '0;
        dump_word[flow_pkg::dump_tag_msb:flow_pkg::dump_tag_lsb]   = tag;
        dump_word[flow_pkg::dump_port_msb:flow_pkg::dump_port_lsb] =
            port_num[flow_pkg::port_bits-1:0];
        dump_word[flow_pkg::dump_cnt_msb:flow_pkg::dump_cnt_lsb]   = cnt;
    end

endmodule

// File: src/flow_pkg.sv
package flow_pkg;

    //////////////////////////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////////////////////////

    localparam int num_in_ports  = 2;
    localparam int num_out_ports = 2;
    localparam int leaf_bits     = 4;
    localparam int port_bits     = 4;
    localparam int payload_bits  = 32;
    localparam int cnt_bits      = 26;
    localparam int fifo_depth    = 4;

    // input queue i answers network port in_port_base + i
    localparam int in_port_base  = 2;
    // port number reported for output queue 0
    localparam int out_port_base = 9;

    // read, empty and full per input queue, full and empty per output queue
    localparam int dump_len = 3 * num_in_ports + 2 * num_out_ports;

    //////////////////////////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////////////////////////

    typedef logic [payload_bits-1:0] payload_t;
    typedef logic [cnt_bits-1:0]     cnt_t;

    // 1 + 4 + 4 + 32 = 41 bits
    typedef struct packed {
        logic                 valid;
        logic [leaf_bits-1:0] leaf;
        logic [port_bits-1:0] port;
        payload_t             payload;
    } packet_t;

    typedef enum logic [1:0] {
        tag_read  = 2'd1,
        tag_empty = 2'd2,
        tag_full  = 2'd3
    } cnt_tag_t;

    // dump word fields
    localparam int dump_tag_msb  = 31;
    localparam int dump_tag_lsb  = 30;
    localparam int dump_port_msb = 29;
    localparam int dump_port_lsb = 26;
    localparam int dump_cnt_msb  = 25;
    localparam int dump_cnt_lsb  = 0;

endpackage

// File: src/input_port_cluster.sv
`timescale 1ns/1ps

module input_port_cluster (
    input  logic              clk,
    input  logic              reset,
    input  flow_pkg::packet_t stream_in,
    input  logic              is_done_mode,
    output flow_pkg::payload_t dout [flow_pkg::num_in_ports],
    output logic              vld  [flow_pkg::num_in_ports],
    input  logic              ack  [flow_pkg::num_in_ports],
    output flow_pkg::cnt_t    full_cnt  [flow_pkg::num_in_ports],
    output flow_pkg::cnt_t    empty_cnt [flow_pkg::num_in_ports],
    output flow_pkg::cnt_t    read_cnt  [flow_pkg::num_in_ports]
);

    for (genvar i = 0; i < flow_pkg::num_in_ports; i++) begin : g_port

        logic           wr_en;
        logic           q_empty;
        logic           q_full;
        flow_pkg::cnt_t full_q;
        flow_pkg::cnt_t empty_q;
        flow_pkg::cnt_t read_q;

        // port decode, anything outside the range matches no queue
        assign wr_en = stream_in.valid &&
                       (stream_in.port == flow_pkg::port_bits'(flow_pkg::in_port_base + i));

        // full queue drops the packet, no credit path back
        port_fifo #(
            .entry_t (flow_pkg::payload_t)
        ) i_fifo (
            .clk     (clk),
            .reset   (reset),
            .wr_en   (wr_en),
            .wr_data (stream_in.payload),
            .rd_en   (ack[i]),
            .rd_data (dout[i]),
            .empty   (q_empty),
            .full    (q_full)
        );

        assign vld[i] = !q_empty;

        //////////////////////////////////////////////////////////////////////
        // queue statistics, frozen once done mode is set
        //////////////////////////////////////////////////////////////////////

        always_ff @(posedge clk) begin
            if (reset) begin
                full_q  <= '0;
                empty_q <= '0;
                read_q  <= '0;
            end else if (!is_done_mode) begin
                if (q_full) begin
                    full_q <= full_q + flow_pkg::cnt_t'(1);
                end
                if (q_empty) begin
                    empty_q <= empty_q + flow_pkg::cnt_t'(1);
                end
                // completed handshake only
                if (vld[i] && ack[i]) begin
                    read_q <= read_q + flow_pkg::cnt_t'(1);
                end
            end
        end

        assign full_cnt[i]  = full_q;
        assign empty_cnt[i] = empty_q;
        assign read_cnt[i]  = read_q;

    end

endmodule

// File: src/output_port_cluster.sv
`timescale 1ns/1ps

module output_port_cluster (
    input  logic               clk,
    input  logic               reset,
    input  flow_pkg::payload_t din       [flow_pkg::num_out_ports],
    input  logic               vld_in    [flow_pkg::num_out_ports],
    output logic               ack_in    [flow_pkg::num_out_ports],
    input  logic [flow_pkg::leaf_bits-1:0] dest_leaf [flow_pkg::num_out_ports],
    input  logic [flow_pkg::port_bits-1:0] dest_port [flow_pkg::num_out_ports],
    input  logic               dump_valid,
    input  flow_pkg::payload_t dump_word,
    output logic               dump_taken,
    input  logic               is_done_mode,
    input  logic               rd_en_sel   [flow_pkg::num_out_ports],
    output flow_pkg::packet_t  out_packets [flow_pkg::num_out_ports],
    output logic               empty       [flow_pkg::num_out_ports],
    output flow_pkg::cnt_t     full_cnt    [flow_pkg::num_out_ports],
    output flow_pkg::cnt_t     empty_cnt   [flow_pkg::num_out_ports]
);

    logic ready;
    logic q_full [flow_pkg::num_out_ports];

    // writes open one cycle after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            ready <= 1'b0;
        end else begin
            ready <= 1'b1;
        end
    end

    // dump words only go through queue 0
    assign dump_taken = dump_valid && ready && !q_full[0];

    for (genvar i = 0; i < flow_pkg::num_out_ports; i++) begin : g_port

        logic               use_dump;
        logic               wr_en;
        flow_pkg::payload_t wr_payload;
        flow_pkg::packet_t  wr_pkt;
        flow_pkg::cnt_t     full_q;
        flow_pkg::cnt_t     empty_q;

        assign use_dump   = dump_valid && (i == 0);
        assign wr_payload = use_dump ? dump_word : din[i];

        // user is held off while the dump owns the queue
        assign ack_in[i] = ready && !q_full[i] && !use_dump;
        assign wr_en     = ready && !q_full[i] && (use_dump || vld_in[i]);

        // address comes from the port configuration
        assign wr_pkt = '{valid: 1'b1, leaf: dest_leaf[i], port: dest_port[i],
                          payload: wr_payload};

        port_fifo #(
            .entry_t (flow_pkg::packet_t)
        ) i_fifo (
            .clk     (clk),
            .reset   (reset),
            .wr_en   (wr_en),
            .wr_data (wr_pkt),
            .rd_en   (rd_en_sel[i]),
            .rd_data (out_packets[i]),
            .empty   (empty[i]),
            .full    (q_full[i])
        );

        //////////////////////////////////////////////////////////////////////
        // full and empty cycle counts
        //////////////////////////////////////////////////////////////////////

        always_ff @(posedge clk) begin
            if (reset) begin
                full_q  <= '0;
                empty_q <= '0;
            end else if (!is_done_mode) begin
                if (q_full[i]) begin
                    full_q <= full_q + flow_pkg::cnt_t'(1);
                end
                if (empty[i]) begin
                    empty_q <= empty_q + flow_pkg::cnt_t'(1);
                end
            end
        end

        assign full_cnt[i]  = full_q;
        assign empty_cnt[i] = empty_q;

    end

endmodule

// File: src/port_fifo.sv
`timescale 1ns/1ps

module port_fifo #(
    parameter type entry_t = flow_pkg::payload_t
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   wr_en,
    input  entry_t wr_data,
    input  logic   rd_en,
    output entry_t rd_data,
    output logic   empty,
    output logic   full
);

    entry_t mem [flow_pkg::fifo_depth];

    logic [$clog2(flow_pkg::fifo_depth)-1:0]   wr_ptr;
    logic [$clog2(flow_pkg::fifo_depth)-1:0]   rd_ptr;
    logic [$clog2(flow_pkg::fifo_depth+1)-1:0] count;

    logic do_wr;
    logic do_rd;

    // a write while full or a read while empty is dropped
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    assign empty   = (count == '0);
    assign full    = (int'(count) == flow_pkg::fifo_depth);
    // head of queue, shown without a register stage
    assign rd_data = mem[rd_ptr];

    // storage
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // pointers wrap at the last entry
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                if (int'(wr_ptr) == flow_pkg::fifo_depth - 1) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (do_rd) begin
                if (int'(rd_ptr) == flow_pkg::fifo_depth - 1) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            // occupancy, unchanged on push and pop together
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: src/stream_flow_control.sv
`timescale 1ns/1ps

module stream_flow_control (
    input  logic               clk,
    input  logic               reset,
    input  flow_pkg::packet_t  stream_in,
    output flow_pkg::packet_t  stream_out,
    output flow_pkg::payload_t dout_to_user  [flow_pkg::num_in_ports],
    output logic               vld_to_user   [flow_pkg::num_in_ports],
    input  logic               ack_from_user [flow_pkg::num_in_ports],
    input  flow_pkg::payload_t din_from_user [flow_pkg::num_out_ports],
    input  logic               vld_from_user [flow_pkg::num_out_ports],
    output logic               ack_to_user   [flow_pkg::num_out_ports],
    input  logic [flow_pkg::leaf_bits-1:0] out_dest_leaf [flow_pkg::num_out_ports],
    input  logic [flow_pkg::port_bits-1:0] out_dest_port [flow_pkg::num_out_ports],
    input  logic               is_done
);

    logic               is_done_mode;
    logic               dump_valid;
    logic               dump_taken;
    flow_pkg::payload_t dump_word;

    // merge path
    logic              rd_en_sel   [flow_pkg::num_out_ports];
    logic              out_empty   [flow_pkg::num_out_ports];
    flow_pkg::packet_t out_packets [flow_pkg::num_out_ports];

    // queue statistics
    flow_pkg::cnt_t in_full_cnt   [flow_pkg::num_in_ports];
    flow_pkg::cnt_t in_empty_cnt  [flow_pkg::num_in_ports];
    flow_pkg::cnt_t in_read_cnt   [flow_pkg::num_in_ports];
    flow_pkg::cnt_t out_full_cnt  [flow_pkg::num_out_ports];
    flow_pkg::cnt_t out_empty_cnt [flow_pkg::num_out_ports];

    input_port_cluster i_ipc (
        .clk (clk), .reset (reset),
        .stream_in (stream_in), .is_done_mode (is_done_mode),
        .dout (dout_to_user), .vld (vld_to_user), .ack (ack_from_user),
        .full_cnt (in_full_cnt), .empty_cnt (in_empty_cnt), .read_cnt (in_read_cnt)
    );

    output_port_cluster i_opc (
        .clk (clk), .reset (reset),
        .din (din_from_user), .vld_in (vld_from_user), .ack_in (ack_to_user),
        .dest_leaf (out_dest_leaf), .dest_port (out_dest_port),
        .dump_valid (dump_valid), .dump_word (dump_word), .dump_taken (dump_taken),
        .is_done_mode (is_done_mode), .rd_en_sel (rd_en_sel),
        .out_packets (out_packets), .empty (out_empty),
        .full_cnt (out_full_cnt), .empty_cnt (out_empty_cnt)
    );

    converge_ctrl i_merge (
        .clk (clk), .reset (reset),
        .empty (out_empty), .out_packets (out_packets),
        .rd_en_sel (rd_en_sel), .stream_out (stream_out)
    );

    counter_dump_seq i_dump (
        .clk (clk), .reset (reset),
        .is_done (is_done), .is_done_mode (is_done_mode),
        .in_full_cnt (in_full_cnt), .in_empty_cnt (in_empty_cnt),
        .in_read_cnt (in_read_cnt), .out_full_cnt (out_full_cnt),
        .out_empty_cnt (out_empty_cnt),
        .dump_valid (dump_valid), .dump_word (dump_word), .dump_taken (dump_taken)
    );

endmodule

// File: test/tb_stream_flow_control.sv
`timescale 1ns/1ps

module tb_stream_flow_control;

    localparam int n_in  = flow_pkg::num_in_ports;
    localparam int n_out = flow_pkg::num_out_ports;
    // five times the longest expected run
    localparam int max_cycles = 5 * 600;

    logic                           clk;
    logic                           reset;
    logic                           is_done;
    flow_pkg::packet_t              stream_in;
    flow_pkg::packet_t              stream_out;
    flow_pkg::payload_t             dout_to_user  [n_in];
    logic                           vld_to_user   [n_in];
    logic                           ack_from_user [n_in];
    flow_pkg::payload_t             din_from_user [n_out];
    logic                           vld_from_user [n_out];
    logic                           ack_to_user   [n_out];
    logic [flow_pkg::leaf_bits-1:0] out_dest_leaf [n_out];
    logic [flow_pkg::port_bits-1:0] out_dest_port [n_out];

    integer seed;
    int     errors        = 0;
    int     cycles        = 0;
    int     stream_count  = 0;
    int     reads [n_in]  = '{default: 0};
    int     writes [n_out] = '{default: 0};
    logic   dump_phase;
    logic   out_active;

    // reference queues per port and the dump words seen on the stream
    flow_pkg::payload_t exp_in  [n_in][$];
    flow_pkg::payload_t exp_out [n_out][$];
    flow_pkg::payload_t dump_seen [$];

    stream_flow_control i_dut (
        .clk (clk), .reset (reset),
        .stream_in (stream_in), .stream_out (stream_out),
        .dout_to_user (dout_to_user), .vld_to_user (vld_to_user),
        .ack_from_user (ack_from_user), .din_from_user (din_from_user),
        .vld_from_user (vld_from_user), .ack_to_user (ack_to_user),
        .out_dest_leaf (out_dest_leaf), .out_dest_port (out_dest_port),
        .is_done (is_done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    // dump order is input reads, empties and fulls, then output fulls and empties
    function automatic logic [1:0] dump_tag_for(input int idx);
        if (idx < n_in) return flow_pkg::tag_read;
        if (idx < 2 * n_in) return flow_pkg::tag_empty;
        if (idx < 3 * n_in + n_out) return flow_pkg::tag_full;
        return flow_pkg::tag_empty;
    endfunction

    function automatic logic [3:0] dump_port_for(input int idx);
        int p;
        if (idx < 3 * n_in) begin
            p = flow_pkg::in_port_base + idx % n_in;
        end else begin
            p = flow_pkg::out_port_base + (idx - 3 * n_in) % n_out;
        end
        return p[3:0];
    endfunction

    function automatic logic inputs_pending();
        logic any;
        any = 1'b0;
        for (int i = 0; i < n_in; i++) begin
            any = any | vld_to_user[i];
        end
        return any;
    endfunction

    function automatic logic out_queues_empty();
        logic all_empty;
        all_empty = 1'b1;
        for (int i = 0; i < n_out; i++) begin
            all_empty = all_empty & i_dut.out_empty[i];
        end
        return all_empty;
    endfunction

    // random acks until no input queue holds data
    task automatic drain_inputs();
        logic [31:0] r;
        stream_in <= '0;
        @(posedge clk);
        while (inputs_pending()) begin
            r = next_rand();
            for (int i = 0; i < n_in; i++) begin
                ack_from_user[i] <= r[i];
            end
            @(posedge clk);
        end
        for (int i = 0; i < n_in; i++) begin
            ack_from_user[i] <= 1'b0;
        end
    endtask

    // output queues empty and the stream register idle
    task automatic wait_stream_idle();
        @(posedge clk);
        while (!out_queues_empty() || stream_out.valid) begin
            @(posedge clk);
        end
    endtask

    task automatic pulse_done();
        is_done <= 1'b1;
        @(posedge clk);
        is_done <= 1'b0;
    endtask

    task automatic check_dump();
        flow_pkg::payload_t w;
        assert (dump_seen.size() == flow_pkg::dump_len) else begin
            errors++;
            $display("ERROR dump word count got %h expected %h", dump_seen.size(),
                     flow_pkg::dump_len);
        end
        for (int k = 0; k < dump_seen.size() && k < flow_pkg::dump_len; k++) begin
            w = dump_seen[k];
            assert (w[31:30] == dump_tag_for(k)) else begin
                errors++;
                $display("ERROR dump tag %0d got %h expected %h", k, w[31:30], dump_tag_for(k));
            end
            assert (w[29:26] == dump_port_for(k)) else begin
                errors++;
                $display("ERROR dump port %0d got %h expected %h", k, w[29:26],
                         dump_port_for(k));
            end
            // read counts against the handshakes seen here
            if (k < n_in) begin
                assert (w[25:0] == 26'(reads[k])) else begin
                    errors++;
                    $display("ERROR read count %0d got %h expected %h", k, w[25:0], reads[k]);
                end
            end else if (dump_tag_for(k) == flow_pkg::tag_empty) begin
                assert (w[25:0] != '0) else begin
                    errors++;
                    $display("ERROR empty count %0d got %h expected nonzero", k, w[25:0]);
                end
            end
            // paced writes never fill output port 1
            if (k == 3 * n_in + 1) begin
                assert (w[25:0] == '0) else begin
                    errors++;
                    $display("ERROR out port 1 full count got %h expected 0", w[25:0]);
                end
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // reset values
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        out_active = stream_out.valid;
        for (int i = 0; i < n_in; i++) begin
            out_active = out_active | vld_to_user[i];
        end
        for (int i = 0; i < n_out; i++) begin
            out_active = out_active | ack_to_user[i];
        end
    end

    assert property (@(posedge clk) reset |=> !out_active) else begin
        errors++;
        $display("ERROR out_active got %h expected 0", out_active);
    end

    //////////////////////////////////////////////////////////////////////
    // monitor sees the values from before each edge
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        int                 q;
        flow_pkg::payload_t want;
        if (!reset) begin
            for (int i = 0; i < n_in; i++) begin
                assert (vld_to_user[i] == (exp_in[i].size() != 0)) else begin
                    errors++;
                    $display("ERROR vld_to_user[%0d] got %h expected %h", i, vld_to_user[i],
                             exp_in[i].size() != 0);
                end
            end
            // packet kept unless port out of range or queue full
            if (stream_in.valid) begin
                q = int'(stream_in.port) - flow_pkg::in_port_base;
                if (q >= 0 && q < n_in && exp_in[q].size() < flow_pkg::fifo_depth) begin
                    exp_in[q].push_back(stream_in.payload);
                end
            end
            for (int i = 0; i < n_in; i++) begin
                if (vld_to_user[i] && ack_from_user[i] && exp_in[i].size() != 0) begin
                    want = exp_in[i].pop_front();
                    reads[i]++;
                    assert (dout_to_user[i] == want) else begin
                        errors++;
                        $display("ERROR dout_to_user[%0d] got %h expected %h", i,
                                 dout_to_user[i], want);
                    end
                end
            end
            // user writes
            for (int i = 0; i < n_out; i++) begin
                if (vld_from_user[i] && ack_to_user[i]) begin
                    exp_out[i].push_back(din_from_user[i]);
                    writes[i]++;
                end
            end
            if (stream_out.valid) begin
                stream_count++;
                if (dump_phase) begin
                    assert (stream_out.port == out_dest_port[0] &&
                            stream_out.leaf == out_dest_leaf[0]) else begin
                        errors++;
                        $display("ERROR stream_out.port got %h expected %h", stream_out.port,
                                 out_dest_port[0]);
                    end
                    dump_seen.push_back(stream_out.payload);
                end else begin
                    q = -1;
                    for (int i = 0; i < n_out; i++) begin
                        if (stream_out.port == out_dest_port[i]) begin
                            q = i;
                        end
                    end
                    if (q < 0 || exp_out[q].size() == 0) begin
                        errors++;
                        $display("stream_out carried a packet that no output port was sent");
                    end else begin
                        want = exp_out[q].pop_front();
                        assert (stream_out.leaf == out_dest_leaf[q]) else begin
                            errors++;
                            $display("ERROR stream_out.leaf got %h expected %h",
                                     stream_out.leaf, out_dest_leaf[q]);
                        end
                        assert (stream_out.payload == want) else begin
                            errors++;
                            $display("ERROR stream_out.payload got %h expected %h",
                                     stream_out.payload, want);
                        end
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] r;
        logic [3:0]  p;
        int          base_reads;
        seed       = 32'h33762e68;
        reset      = 1'b1;
        is_done    = 1'b0;
        stream_in  = '0;
        dump_phase = 1'b0;
        for (int i = 0; i < n_in; i++) begin
            ack_from_user[i] = 1'b0;
        end
        for (int i = 0; i < n_out; i++) begin
            din_from_user[i] = '0;
            vld_from_user[i] = 1'b0;
        end
        out_dest_leaf = '{4'h3, 4'hc};
        out_dest_port = '{4'h5, 4'h6};
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        // packets to ports 2, 3 and the unused port 7 with random acks
        for (int n = 0; n < 40; n++) begin
            r = next_rand();
            p = (r[1:0] == 2'd3) ? 4'd7 : (r[0] ? 4'd3 : 4'd2);
            stream_in <= '{valid: r[2], leaf: 4'h0, port: p, payload: next_rand()};
            ack_from_user[0] <= r[3];
            ack_from_user[1] <= r[4];
            @(posedge clk);
        end
        drain_inputs();

        // six to port 3 with ack low so the queue keeps four
        base_reads = reads[1];
        for (int n = 0; n < 6; n++) begin
            stream_in <= '{valid: 1'b1, leaf: 4'h0, port: 4'd3, payload: next_rand()};
            @(posedge clk);
        end
        drain_inputs();
        assert (reads[1] - base_reads == 4) else begin
            errors++;
            $display("ERROR reads on port 3 got %h expected %h", reads[1] - base_reads, 4);
        end

        // random user writes with port 1 only on odd cycles
        for (int n = 0; n < 60; n++) begin
            r = next_rand();
            vld_from_user[0] <= r[0];
            din_from_user[0] <= next_rand();
            vld_from_user[1] <= r[1] & n[0];
            din_from_user[1] <= next_rand();
            @(posedge clk);
        end
        vld_from_user[0] <= 1'b0;
        vld_from_user[1] <= 1'b0;
        wait_stream_idle();
        for (int i = 0; i < n_out; i++) begin
            assert (writes[i] != 0) else begin
                errors++;
                $display("output port %0d accepted no user writes", i);
            end
            if (exp_out[i].size() != 0) begin
                errors++;
                $display("output port %0d has %0d words that never reached stream_out", i,
                         exp_out[i].size());
            end
        end

        // counter dump and then a second pulse that must add nothing
        dump_phase <= 1'b1;
        @(posedge clk);
        pulse_done();
        while (dump_seen.size() < flow_pkg::dump_len) begin
            @(posedge clk);
        end
        repeat (20) @(posedge clk);
        pulse_done();
        repeat (20) @(posedge clk);
        check_dump();

        $display("run done: %0d errors, %0d stream packets, %0d dump words", errors,
                 stream_count, dump_seen.size());
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // cycle limit
    initial begin
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the tests did not finish, %0d errors", cycles,
                 errors);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule
